// File: turfio_hsk_top.f
+incdir+design
design/turfio_hsk_pkg.sv
design/surf_uart_retimer.sv
design/hsk_uart_router.sv
design/hskbus_frame_counter.sv
design/turfio_hsk_top.sv
sim/turfio_hsk_checker.sv
sim/turfio_hsk_tb.sv

// File: Bender.yml
package:
  name: turfio_hsk

sources:
  - include_dirs:
      - design
    files:
      - design/turfio_hsk_pkg.sv
      - design/surf_uart_retimer.sv
      - design/hsk_uart_router.sv
      - design/hskbus_frame_counter.sv
      - design/turfio_hsk_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - sim/turfio_hsk_checker.sv
      - sim/turfio_hsk_tb.sv

// File: sim/turfio_hsk_tb.sv
`timescale 1ns/1ps
`include "turfio_hsk_defines.svh"

module turfio_hsk_tb;

    logic                       init_clk;
    logic                       rst_n_i;
    turfio_hsk_pkg::host_uart_t host_rx_i;
    logic                       tctrl_b_i;
    logic                       hsk_local_i;
    logic                       crate_enable_i;
    logic                       surf_tx_i;
    turfio_hsk_pkg::host_uart_t host_tx_o;
    logic                       surf_rx_o;
    logic [`HSK_CNT_W-1:0]      hskbus_rx_frames_o;
    // Reference levels handed to the checker
    turfio_hsk_pkg::host_uart_t exp_tx;
    logic                       exp_surf;
    logic [2:0]                 mask;
    // Frames the counter should have seen
    logic [`HSK_CNT_W-1:0]      exp_frames;

    turfio_hsk_top uut (.*);

    turfio_hsk_checker u_chk (
        .init_clk   (init_clk),
        .host_tx_i  (host_tx_o),
        .surf_rx_i  (surf_rx_o),
        .frames_i   (hskbus_rx_frames_o),
        .exp_tx_i   (exp_tx),
        .exp_surf_i (exp_surf),
        .mask_i     (mask)
    );

    ////////////////////
    // Reference model
    ////////////////////

    // Routing table plus crate gating, returns {host lines, surf_rx}
    function automatic logic [4:0] expected_route(input turfio_hsk_pkg::host_uart_t rx,
                                                  input logic local_ovr, input logic tctrl_b,
                                                  input logic en, input logic retimed);
        turfio_hsk_pkg::host_uart_t tx;
        logic ret;
        logic to_crate;
        tx  = '1;
        ret = en ? retimed : 1'b1;
        if (local_ovr) begin
            to_crate  = rx.dbg_rx;
            tx.dbg_tx = ret;
        end else begin
            // TURF always hears the crate unless local
            to_crate   = tctrl_b ? 1'b1 : rx.turf_rx;
            tx.turf_tx = ret;
        end
        return {tx, en ? to_crate : 1'b1};
    endfunction

    ////////////////////
    // Stimulus
    ////////////////////

    // New mode and random host levels, SURF line idle
    task automatic apply(input logic local_ovr, input logic tctrl_b, input logic en,
                         input logic [2:0] chk);
        turfio_hsk_pkg::host_uart_t rx;
        rx         = '1;
        rx.dbg_rx  = $urandom_range(1, 0);
        rx.turf_rx = $urandom_range(1, 0);
        @(posedge init_clk);
        #2;
        host_rx_i          = rx;
        hsk_local_i        = local_ovr;
        tctrl_b_i          = tctrl_b;
        crate_enable_i     = en;
        {exp_tx, exp_surf} = expected_route(rx, local_ovr, tctrl_b, en, 1'b1);
        mask               = chk;
    endtask

    // One 8N1 frame on the SURF line, LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [`HSK_FRAME_BITS-1:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < `HSK_FRAME_BITS; i++) begin
            @(posedge init_clk);
            #2;
            surf_tx_i = frame[i];
            repeat (`HSK_BAUD_PERIOD - 1) @(posedge init_clk);
        end
    endtask

    task automatic send_frames(input int n, input logic use_dbg, input logic decode);
        logic [7:0] b;
        repeat (n) begin
            b = $urandom_range(255, 0);
            if (decode) begin
                fork
                    send_byte(b);
                    u_chk.receive_frame(use_dbg, b);
                join
            end else begin
                send_byte(b);
            end
        end
    endtask

    initial begin
        init_clk = 1'b0;
        forever #10 init_clk = ~init_clk;
    end

    initial begin
        void'($urandom(61));
        rst_n_i        = 1'b0;
        host_rx_i      = '1;
        tctrl_b_i      = 1'b1;
        hsk_local_i    = 1'b0;
        // Crate on, so the retimer level reaches turf_tx
        crate_enable_i = 1'b1;
        surf_tx_i      = 1'b1;
        exp_tx         = '1;
        exp_surf       = 1'b1;
        mask           = 3'b111;
        exp_frames     = '0;
        repeat (3) @(posedge init_clk);
        #2;
        rst_n_i = 1'b1;

        // Idle lines, empty count, retimer output on turf_tx
        apply(1'b0, 1'b1, 1'b1, 3'b111);
        u_chk.wait_count(exp_frames);
        u_chk.end_test("reset");

        // All eight mode and enable combinations
        for (int c = 0; c < 8; c++) begin
            repeat (4) apply(c[2], c[1], c[0], 3'b111);
        end
        u_chk.end_test("static routing");

        // TURF mode, dbg_tx must stay idle
        apply(1'b0, 1'b0, 1'b1, 3'b010);
        send_frames(20, 1'b0, 1'b1);
        exp_frames = exp_frames + 8'd20;
        u_chk.wait_count(exp_frames);
        u_chk.end_test("retimed return on turf_tx");

        // Local override, turf_tx must stay idle
        apply(1'b1, 1'b0, 1'b1, 3'b001);
        send_frames(4, 1'b1, 1'b1);
        exp_frames = exp_frames + 8'd4;
        u_chk.wait_count(exp_frames);
        u_chk.end_test("retimed return on dbg_tx");

        // Enough frames to wrap the count
        apply(1'b0, 1'b0, 1'b1, 3'b010);
        send_frames(240, 1'b0, 1'b1);
        exp_frames = exp_frames + 8'd240;
        u_chk.wait_count(exp_frames);
        // Crate off, nothing gets through
        apply(1'b0, 1'b0, 1'b0, 3'b111);
        send_frames(3, 1'b0, 1'b0);
        u_chk.wait_count(exp_frames);
        u_chk.end_test("frame count");

        u_chk.report();
        if (u_chk.fail_cnt == 0 && u_chk.err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sim/turfio_hsk_checker.sv
`timescale 1ns/1ps
`include "turfio_hsk_defines.svh"

module turfio_hsk_checker (
    input logic                       init_clk,
    input turfio_hsk_pkg::host_uart_t host_tx_i,
    input logic                       surf_rx_i,
    input logic [`HSK_CNT_W-1:0]      frames_i,
    // Expected levels from the routing reference
    input turfio_hsk_pkg::host_uart_t exp_tx_i,
    input logic                       exp_surf_i,
    // Compare enables, {surf_rx, dbg_tx, turf_tx}
    input logic [2:0]                 mask_i
);

    localparam int wait_lim = 4 * `HSK_BAUD_PERIOD;

    int err_cnt  = 0;
    int test_err = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    ////////////////////
    // Level compare
    ////////////////////

    // Falling edge, well away from input changes
    always @(negedge init_clk) begin : level_cmp
        logic [2:0] got;
        logic [2:0] exp;
        got = {surf_rx_i, host_tx_i.dbg_tx, host_tx_i.turf_tx};
        exp = {exp_surf_i, exp_tx_i.dbg_tx, exp_tx_i.turf_tx};
        if ((got & mask_i) !== (exp & mask_i)) begin
            $display("[ERROR] %0t: surf_rx/dbg_tx/turf_tx = %b, expected %b, mask %b",
                     $time, got, exp, mask_i);
            err_cnt++;
        end
        // Rx fields of the output bundle are tied high
        if ({host_tx_i.dbg_rx, host_tx_i.turf_rx} !== 2'b11) begin
            $display("[ERROR] %0t: host_tx dbg_rx/turf_rx = %b, expected 11",
                     $time, {host_tx_i.dbg_rx, host_tx_i.turf_rx});
            err_cnt++;
        end
    end

    ////////////////////
    // Frame decode
    ////////////////////

    // Start edge, then mid-bit samples of all ten bits
    task automatic receive_frame(input logic use_dbg, input logic [7:0] exp_b);
        int t;
        logic [`HSK_FRAME_BITS-1:0] bits;
        t = 0;
        while ((use_dbg ? host_tx_i.dbg_tx : host_tx_i.turf_tx) !== 1'b0 && t < wait_lim) begin
            @(negedge init_clk);
            t++;
        end
        if (t >= wait_lim) begin
            $display("Timeout: no start bit seen on %s", use_dbg ? "dbg_tx" : "turf_tx");
            err_cnt++;
        end else begin
            repeat (`HSK_BAUD_PERIOD / 2) @(negedge init_clk);
            for (int i = 0; i < `HSK_FRAME_BITS; i++) begin
                bits[i] = use_dbg ? host_tx_i.dbg_tx : host_tx_i.turf_tx;
                repeat (`HSK_BAUD_PERIOD) @(negedge init_clk);
            end
            // Stop high, data LSB first, start low
            if (bits !== {1'b1, exp_b, 1'b0}) begin
                $display("[ERROR] %0t: frame %b on %s, expected byte %h", $time, bits,
                         use_dbg ? "dbg_tx" : "turf_tx", exp_b);
                err_cnt++;
            end
        end
    endtask

    // Count lands at the stop sample, so poll for it
    task automatic wait_count(input logic [`HSK_CNT_W-1:0] exp_cnt);
        int t;
        t = 0;
        while (frames_i !== exp_cnt && t < wait_lim) begin
            @(negedge init_clk);
            t++;
        end
        if (frames_i !== exp_cnt) begin
            $display("[ERROR] %0t: frame count %0d, expected %0d", $time, frames_i, exp_cnt);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("Test %s: %s", name, (err_cnt == test_err) ? "ok" : "failed");
        test_err = err_cnt;
    endtask

    task automatic report();
        $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    endtask

endmodule

// File: design/turfio_hsk_top.sv
`timescale 1ns/1ps
`include "turfio_hsk_defines.svh"

module turfio_hsk_top (
    input  logic                       init_clk,
    input  logic                       rst_n_i,
    // Only dbg_rx and turf_rx are used
    input  turfio_hsk_pkg::host_uart_t host_rx_i,
    input  logic                       tctrl_b_i,
    input  logic                       hsk_local_i,
    input  logic                       crate_enable_i,
    // Open-drain return from the SURFs
    input  logic                       surf_tx_i,
    // Only dbg_tx and turf_tx carry data
    output turfio_hsk_pkg::host_uart_t host_tx_o,
    output logic                       surf_rx_o,
    output logic [`HSK_CNT_W-1:0]      hskbus_rx_frames_o
);

    // Retimer to router
    logic                        retimed;
    // Router to crate and counter
    turfio_hsk_pkg::crate_uart_t crate;

    ////////////////////
    // Return line cleanup
    ////////////////////

    surf_uart_retimer u_retimer (
        .init_clk       (init_clk),
        .rst_n_i        (rst_n_i),
        .crate_enable_i (crate_enable_i),
        .surf_tx_i      (surf_tx_i),
        .retimed_o      (retimed)
    );

    ////////////////////
    // Routing
    ////////////////////

    hsk_uart_router u_router (
        .host_rx_i      (host_rx_i),
        .tctrl_b_i      (tctrl_b_i),
        .hsk_local_i    (hsk_local_i),
        .crate_enable_i (crate_enable_i),
        .retimed_i      (retimed),
        .host_tx_o      (host_tx_o),
        .crate_o        (crate)
    );

    assign surf_rx_o = crate.to_crate;

    // Frames seen coming back from the crate
    hskbus_frame_counter u_frame_cnt (
        .init_clk (init_clk),
        .rst_n_i  (rst_n_i),
        .crate_i  (crate),
        .frames_o (hskbus_rx_frames_o)
    );

endmodule

// File: design/hskbus_frame_counter.sv
`timescale 1ns/1ps
`include "turfio_hsk_defines.svh"

module hskbus_frame_counter (
    input  logic                        init_clk,
    input  logic                        rst_n_i,
    input  turfio_hsk_pkg::crate_uart_t crate_i,
    output logic [`HSK_CNT_W-1:0]       frames_o
);

    localparam int cyc_w = $clog2(`HSK_BAUD_PERIOD);
    localparam int bit_w = $clog2(`HSK_FRAME_BITS);

    // Return line is already clean and synchronous
    logic                       rx_line;
    logic                       line_q;
    logic                       fall_edge;
    // Frame tracker
    turfio_hsk_pkg::bit_state_e state_q;
    logic [cyc_w-1:0]           cyc_cnt_q;
    logic [bit_w-1:0]           bit_cnt_q;
    logic                       sample_pt;
    logic                       last_bit;
    // Received frame count
    logic [`HSK_CNT_W-1:0]      frames_q;

    assign rx_line = crate_i.from_crate;

    ////////////////////
    // Start detect
    ////////////////////

    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            line_q <= 1'b1;
        end else begin
            line_q <= rx_line;
        end
    end

    assign fall_edge = line_q & ~rx_line;

    ////////////////////
    // Frame tracker
    ////////////////////

    assign sample_pt = (state_q == turfio_hsk_pkg::BIT_FRAME) && (cyc_cnt_q == '0);
    // Stop bit is the last sample
    assign last_bit  = (bit_cnt_q == bit_w'(`HSK_FRAME_BITS - 1));

    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= turfio_hsk_pkg::BIT_IDLE;
            cyc_cnt_q <= '0;
            bit_cnt_q <= '0;
            frames_q  <= '0;
        end else if (state_q == turfio_hsk_pkg::BIT_IDLE) begin
            bit_cnt_q <= '0;
            if (fall_edge) begin
                state_q   <= turfio_hsk_pkg::BIT_FRAME;
                cyc_cnt_q <= cyc_w'(`HSK_SAMPLE_POINT - 1);
            end
        end else begin
            if (sample_pt) begin
                cyc_cnt_q <= cyc_w'(`HSK_BAUD_PERIOD - 1);
                bit_cnt_q <= bit_cnt_q + 1'b1;
                if (last_bit) begin
                    state_q <= turfio_hsk_pkg::BIT_IDLE;
                    // Framing error, not counted
                    if (rx_line) begin
                        frames_q <= frames_q + 1'b1;
                    end
                end
            end else begin
                cyc_cnt_q <= cyc_cnt_q - 1'b1;
            end
        end
    end

    // Wraps at 2**HSK_CNT_W
    assign frames_o = frames_q;

    // At most one frame per cycle, wrap included
    a_count_step: assert property (
        @(posedge init_clk) disable iff (!rst_n_i)
        (frames_q == $past(frames_q)) || (frames_q == $past(frames_q) + 1'b1)
    ) else $error("frame count jumped by more than one");

endmodule

// File: design/hsk_uart_router.sv
`timescale 1ns/1ps

module hsk_uart_router (
    input  turfio_hsk_pkg::host_uart_t  host_rx_i,
    input  logic                        tctrl_b_i,
    input  logic                        hsk_local_i,
    input  logic                        crate_enable_i,
    input  logic                        retimed_i,
    output turfio_hsk_pkg::host_uart_t  host_tx_o,
    output turfio_hsk_pkg::crate_uart_t crate_o
);

    turfio_hsk_pkg::route_mode_e route_mode;
    // Line toward the crate before gating
    logic                        to_crate_raw;
    // Gated return line
    logic                        from_crate;

    ////////////////////
    // Mode decode
    ////////////////////

    // Local override beats the TURF control strobe
    always_comb begin
        if (hsk_local_i) begin
            route_mode = turfio_hsk_pkg::ROUTE_LOCAL;
        end else if (!tctrl_b_i) begin
            route_mode = turfio_hsk_pkg::ROUTE_TURF;
        end else begin
            route_mode = turfio_hsk_pkg::ROUTE_OFF;
        end
        a_mode_legal: assert (route_mode inside {turfio_hsk_pkg::ROUTE_TURF,
                                                 turfio_hsk_pkg::ROUTE_LOCAL,
                                                 turfio_hsk_pkg::ROUTE_OFF})
            else $error("illegal route mode %0d", route_mode);
    end

    ////////////////////
    // Routing table
    ////////////////////

    // Disabled crate returns idle
    assign from_crate = crate_enable_i ? retimed_i : 1'b1;

    always_comb begin
        // Unused lines idle high, rx fields included
        host_tx_o    = '1;
        to_crate_raw = 1'b1;
        case (route_mode)
            turfio_hsk_pkg::ROUTE_LOCAL: begin
                to_crate_raw     = host_rx_i.dbg_rx;
                host_tx_o.dbg_tx = from_crate;
            end
            turfio_hsk_pkg::ROUTE_TURF: begin
                to_crate_raw      = host_rx_i.turf_rx;
                host_tx_o.turf_tx = from_crate;
            end
            turfio_hsk_pkg::ROUTE_OFF: begin
                // Nothing sent out, TURF can still listen
                host_tx_o.turf_tx = from_crate;
            end
            default: begin
                to_crate_raw = 1'b1;
            end
        endcase
    end

    // Crate gating on the outbound side
    assign crate_o.to_crate   = crate_enable_i ? to_crate_raw : 1'b1;
    assign crate_o.from_crate = from_crate;

endmodule

// File: design/surf_uart_retimer.sv
`timescale 1ns/1ps
`include "turfio_hsk_defines.svh"

module surf_uart_retimer (
    input  logic init_clk,
    input  logic rst_n_i,
    input  logic crate_enable_i,
    input  logic surf_tx_i,
    output logic retimed_o
);

    localparam int cyc_w = $clog2(`HSK_BAUD_PERIOD);
    localparam int bit_w = $clog2(`HSK_FRAME_BITS);

    // Synchroniser stages and edge history
    logic [1:0]                 sync_q;
    logic                       line_q;
    logic                       fall_edge;
    // Frame tracker
    turfio_hsk_pkg::bit_state_e state_q;
    logic [cyc_w-1:0]           cyc_cnt_q;
    logic [bit_w-1:0]           bit_cnt_q;
    logic                       sample_pt;
    logic                       last_bit;
    // Regenerated line
    logic                       retimed_q;

    ////////////////////
    // Input synchroniser
    ////////////////////

    // SURF line is open drain and asynchronous to init_clk
    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= 2'b11;
            line_q <= 1'b1;
        end else begin
            sync_q <= {sync_q[0], surf_tx_i};
            line_q <= sync_q[1];
        end
    end

    // High to low on the synchronised line
    assign fall_edge = line_q & ~sync_q[1];

    ////////////////////
    // Frame tracker
    ////////////////////

    assign sample_pt = (state_q == turfio_hsk_pkg::BIT_FRAME) && (cyc_cnt_q == '0);
    assign last_bit  = (bit_cnt_q == bit_w'(`HSK_FRAME_BITS - 1));

    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= turfio_hsk_pkg::BIT_IDLE;
            cyc_cnt_q <= '0;
            bit_cnt_q <= '0;
            retimed_q <= 1'b1;
        end else if (!crate_enable_i) begin
            // Crate off, park in idle
            state_q   <= turfio_hsk_pkg::BIT_IDLE;
            cyc_cnt_q <= '0;
            bit_cnt_q <= '0;
            retimed_q <= 1'b1;
        end else if (state_q == turfio_hsk_pkg::BIT_IDLE) begin
            retimed_q <= 1'b1;
            bit_cnt_q <= '0;
            if (fall_edge) begin
                // First sample lands inside the start bit
                state_q   <= turfio_hsk_pkg::BIT_FRAME;
                cyc_cnt_q <= cyc_w'(`HSK_SAMPLE_POINT - 1);
            end
        end else begin
            if (sample_pt) begin
                // Regenerate the bit from this sample
                retimed_q <= sync_q[1];
                cyc_cnt_q <= cyc_w'(`HSK_BAUD_PERIOD - 1);
                bit_cnt_q <= bit_cnt_q + 1'b1;
                if (last_bit) begin
                    state_q <= turfio_hsk_pkg::BIT_IDLE;
                end
            end else begin
                cyc_cnt_q <= cyc_cnt_q - 1'b1;
            end
        end
    end

    assign retimed_o = retimed_q;

    // Output edges sit on sample points, or come from dropping back to idle
    a_retime_on_sample: assert property (
        @(posedge init_clk) disable iff (!rst_n_i)
        !$stable(retimed_q) |->
            $past(sample_pt) || ($past(state_q) == turfio_hsk_pkg::BIT_IDLE) ||
            !$past(crate_enable_i)
    ) else $error("retimed_o moved outside a sample point");

endmodule

// File: design/turfio_hsk_pkg.sv
package turfio_hsk_pkg;

    ////////////////////
    // Enumerations
    ////////////////////

    // Where the crate housekeeping bus is attached
    typedef enum logic [1:0] {
        // Crate talks to the TURF UART
        ROUTE_TURF  = 2'b00,
        // Crate talks to the debug UART
        ROUTE_LOCAL = 2'b01,
        // Crate sees idle, return still goes to TURF
        ROUTE_OFF   = 2'b10
    } route_mode_e;

    // Frame tracker state for the retimer and the counter
    typedef enum logic {
        BIT_IDLE  = 1'b0,
        BIT_FRAME = 1'b1
    } bit_state_e;

    ////////////////////
    // Line bundles
    ////////////////////

    // Host side UART lines, all idle high
    typedef struct packed {
        logic dbg_rx;
        logic dbg_tx;
        logic turf_rx;
        logic turf_tx;
    } host_uart_t;

    // Crate side lines
    typedef struct packed {
        // Toward the SURFs
        logic to_crate;
        // Retimed return from the SURFs
        logic from_crate;
    } crate_uart_t;

endpackage

// File: design/turfio_hsk_defines.svh
`ifndef HSK_DEFINES_SVH
`define HSK_DEFINES_SVH

////////////////////
// Housekeeping UART timing
////////////////////

// init_clk cycles per UART bit
`define HSK_BAUD_PERIOD 160

// Start edge to first sample, in init_clk cycles
// Late in the bit so the slow open-drain rise has settled
`define HSK_SAMPLE_POINT 120

////////////////////
// Frame format
////////////////////

// Start bit, 8 data bits, stop bit
`define HSK_FRAME_BITS 10

// Width of the received frame count
`define HSK_CNT_W 8

`endif
